// File: tests/exc_stim.txt
# ev irq id dbg stall epc mret pc_set pc mcause mie priv trap mepc mask, all hex
# ev {ebrk,ecall,ill}, dbg {sste,ecall,ebrk,eill,irq}, mask bit7 set: epc given
# reset state
0 0 00 00 0 00000000 0 0 00000000 00 1 3 0 00000000 7d
# illegal beats irq, irq masked until mret then traps again
1 1 05 00 0 00001000 0 0 00000000 00 1 3 0 00000000 a9
0 1 05 00 0 00000000 0 1 00000108 02 0 3 0 00001000 7f
0 1 05 00 0 00000000 1 0 00000000 00 0 3 0 00000000 29
0 1 05 00 0 00002000 0 0 00000000 00 1 3 0 00000000 99
0 0 00 00 0 00000000 0 1 00000100 25 0 3 0 00002000 7f
# enable stack
0 1 07 00 0 00000000 0 0 00000000 00 0 3 0 00000000 29
0 1 07 00 0 00000000 1 0 00000000 00 0 3 0 00000000 09
0 1 07 00 0 00003000 0 0 00000000 00 1 3 0 00000000 89
0 0 00 00 0 00000000 0 1 00000100 27 0 3 0 00003000 7f
# ecall from machine, two returns down to user, ecall from user
2 0 00 00 0 00004000 0 0 00000000 00 0 3 0 00000000 81
0 0 00 00 0 00000000 1 1 00000104 0b 0 3 0 00004000 7f
0 0 00 00 0 00000000 1 0 00000000 00 0 3 0 00000000 19
0 0 00 00 0 00000000 0 0 00000000 00 1 0 0 00000000 19
2 0 00 00 0 00005000 0 0 00000000 00 0 0 0 00000000 91
0 0 00 00 0 00000000 0 1 00000104 08 0 3 0 00005000 7f
0 0 00 00 0 00000000 1 0 00000000 00 0 0 0 00000000 01
0 0 00 00 0 00000000 0 0 00000000 00 1 0 0 00000000 19
# irq under a three cycle stall, id changes while waiting
0 1 03 00 1 00006000 0 0 00000000 08 0 0 0 00000000 85
0 1 0a 00 1 00000000 0 0 00000000 00 0 0 0 00000000 01
0 1 0a 00 1 00000000 0 0 00000000 00 0 0 0 00000000 01
0 1 0a 00 0 00007000 0 0 00000000 00 1 0 0 00000000 89
0 0 00 00 0 00000000 0 1 00000100 23 0 3 0 00007000 7f
0 0 00 00 0 00000000 1 0 00000000 00 0 0 0 00000000 01
0 0 00 00 0 00000000 0 0 00000000 00 1 0 0 00000000 19
# debug trap settings
0 0 00 10 0 00000000 0 0 00000000 00 0 0 1 00000000 21
0 0 00 04 0 00000000 0 0 00000000 00 0 0 0 00000000 21
4 0 00 04 0 00000000 0 0 00000000 00 0 0 1 00000000 21
0 1 01 0e 0 00008000 0 0 00000000 00 0 0 0 00000000 a1
4 0 00 0e 0 00000000 0 1 00000100 21 0 3 1 00008000 7f
0 0 00 00 0 00000000 0 0 00000000 21 0 3 0 00000000 25

// File: src.f
+incdir+hw
hw/exc_pkg.sv
hw/exc_controller.sv
hw/trap_sequencer.sv
hw/exc_csr.sv
hw/exc_unit_top.sv
tests/tb_clk_gen.sv
tests/tb_exc_unit.sv

// File: Makefile
TOP = tb_exc_unit

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module exc_unit_top
	verilator --lint-only -Wall --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/tb_exc_unit.sv
`timescale 1ns/1ns
`include "exc_defines.svh"

module tb_exc_unit;
  import exc_pkg::*;

  localparam int MAX_ITER    = 200;
  localparam int RST_TIMEOUT = 20;

  // one stimulus line, inputs then expected outputs
  typedef struct packed {
    logic [2:0]               ev;
    logic                     irq;
    logic [`EXC_IRQ_ID_W-1:0] irq_id;
    logic [4:0]               dbg;
    logic                     stall;
    logic [`EXC_XLEN-1:0]     epc;
    logic                     mret;
    logic                     exp_pc_set;
    logic [`EXC_XLEN-1:0]     exp_pc;
    logic [`EXC_CAUSE_W-1:0]  exp_mcause;
    logic                     exp_mie;
    logic [1:0]               exp_priv;
    logic                     exp_trap;
    logic [`EXC_XLEN-1:0]     exp_mepc;
    logic [7:0]               mask;
  } stim_t;

  logic                     clk;
  logic                     rst_n;

  exc_events_t              events;
  logic                     irq;
  logic [`EXC_IRQ_ID_W-1:0] irq_id;
  dbg_settings_t            dbg_settings;
  logic                     stall;
  logic [`EXC_XLEN-1:0]     epc;
  logic                     mret;

  logic                     pc_set;
  logic [`EXC_XLEN-1:0]     pc;
  exc_cause_u               mcause;
  logic [`EXC_XLEN-1:0]     mepc;
  logic                     mie;
  priv_lvl_e                priv_lvl;
  logic                     dbg_trap;

  int                       err_cnt;
  int                       checked;

  //////////////////////////////////////////////////////////////////////
  // clock, reset and DUT
  //////////////////////////////////////////////////////////////////////

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  exc_unit_top DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .events_i       (events),
    .irq_i          (irq),
    .irq_id_i       (irq_id),
    .dbg_settings_i (dbg_settings),
    .stall_i        (stall),
    .epc_i          (epc),
    .mret_i         (mret),
    .pc_set_o       (pc_set),
    .pc_o           (pc),
    .mcause_o       (mcause),
    .mepc_o         (mepc),
    .mie_o          (mie),
    .priv_lvl_o     (priv_lvl),
    .dbg_trap_o     (dbg_trap)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // fifteen hex columns per data line
  task automatic parse_line(input string line, output stim_t s, output int ok);
    logic [31:0] col [0:14];
    int          n;
    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                col[8], col[9], col[10], col[11], col[12], col[13], col[14]);
    ok           = (n == 15) ? 1 : 0;
    s.ev         = col[0][2:0];
    s.irq        = col[1][0];
    s.irq_id     = col[2][`EXC_IRQ_ID_W-1:0];
    s.dbg        = col[3][4:0];
    s.stall      = col[4][0];
    s.epc        = col[5];
    s.mret       = col[6][0];
    s.exp_pc_set = col[7][0];
    s.exp_pc     = col[8];
    s.exp_mcause = col[9][`EXC_CAUSE_W-1:0];
    s.exp_mie    = col[10][0];
    s.exp_priv   = col[11][1:0];
    s.exp_trap   = col[12][0];
    s.exp_mepc   = col[13];
    s.mask       = col[14][7:0];
  endtask

  task automatic drive_inputs(input stim_t s);
    events       = s.ev;
    irq          = s.irq;
    irq_id       = s.irq_id;
    dbg_settings = s.dbg;
    stall        = s.stall;
    mret         = s.mret;
    // epc only matters on trap cycles, random filler otherwise
    if (s.mask[7]) begin
      epc = s.epc;
    end else begin
      epc = $urandom;
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    err_cnt++;
  endtask

  // mask bits: pc_set pc mcause mie priv trap mepc, low to high
  task automatic compare_outputs(input stim_t s);
    if (s.mask[0] && pc_set !== s.exp_pc_set) begin
      report_mismatch("pc_set_o", 32'(pc_set), 32'(s.exp_pc_set));
    end
    if (s.mask[1] && pc !== s.exp_pc) begin
      report_mismatch("pc_o", pc, s.exp_pc);
    end
    if (s.mask[2] && mcause.raw !== s.exp_mcause) begin
      report_mismatch("mcause_o", 32'(mcause.raw), 32'(s.exp_mcause));
    end
    if (s.mask[3] && mie !== s.exp_mie) begin
      report_mismatch("mie_o", 32'(mie), 32'(s.exp_mie));
    end
    if (s.mask[4] && 2'(priv_lvl) !== s.exp_priv) begin
      report_mismatch("priv_lvl_o", 32'(priv_lvl), 32'(s.exp_priv));
    end
    if (s.mask[5] && dbg_trap !== s.exp_trap) begin
      report_mismatch("dbg_trap_o", 32'(dbg_trap), 32'(s.exp_trap));
    end
    if (s.mask[6] && mepc !== s.exp_mepc) begin
      report_mismatch("mepc_o", mepc, s.exp_mepc);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int    fd;
    int    n;
    int    ok;
    int    iter;
    int    waited;
    string line;
    stim_t cur;

    events       = '0;
    irq          = 1'b0;
    irq_id       = '0;
    dbg_settings = '0;
    stall        = 1'b0;
    epc          = '0;
    mret         = 1'b0;
    err_cnt      = 0;
    checked      = 0;
    void'($urandom(32'h6ee6_43f3));

    fd = $fopen("tests/exc_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file tests/exc_stim.txt");
      err_cnt++;
    end

    // wait for reset release
    waited = 0;
    while (rst_n !== 1'b1 && waited < RST_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end

    if (rst_n !== 1'b1) begin
      $display("reset was still asserted after %0d cycles", RST_TIMEOUT);
      err_cnt++;
    end else if (fd != 0) begin
      iter = 0;
      while (!$feof(fd) && iter < MAX_ITER) begin
        n = $fgets(line, fd);
        iter++;
        // skip blank and comment lines
        if (n > 1 && line.getc(0) != "#") begin
          parse_line(line, cur, ok);
          if (ok == 0) begin
            $display("stimulus line could not be read: %s", line);
            err_cnt++;
          end else begin
            @(posedge clk);
            #2;
            drive_inputs(cur);
            // sample just before the next edge
            #36;
            compare_outputs(cur);
            checked++;
          end
        end
      end
      if (!$feof(fd)) begin
        $display("stimulus file not finished after %0d lines", MAX_ITER);
        err_cnt++;
      end
      $fclose(fd);
    end

    if (checked == 0) begin
      $display("no stimulus line was applied");
      err_cnt++;
    end

    $display("lines checked: %0d, errors: %0d", checked, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int HALF_PERIOD = 20,
  parameter int RST_CYCLES  = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  // free running clock, 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // reset low over the first rising edges, released just after one
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2 rst_n_o = 1'b1;
  end

endmodule

// File: hw/exc_unit_top.sv
`timescale 1ns/1ns
`include "exc_defines.svh"

module exc_unit_top (
  input  logic                      clk,
  input  logic                      rst_n,
  // decode side
  input  exc_pkg::exc_events_t      events_i,
  input  logic                      irq_i,
  input  logic [`EXC_IRQ_ID_W-1:0]  irq_id_i,
  input  exc_pkg::dbg_settings_t    dbg_settings_i,
  input  logic                      stall_i,
  input  logic [`EXC_XLEN-1:0]      epc_i,
  input  logic                      mret_i,
  // fetch redirect
  output logic                      pc_set_o,
  output logic [`EXC_XLEN-1:0]      pc_o,
  // machine trap state
  output exc_pkg::exc_cause_u       mcause_o,
  output logic [`EXC_XLEN-1:0]      mepc_o,
  output logic                      mie_o,
  output exc_pkg::priv_lvl_e        priv_lvl_o,
  // debug unit
  output logic                      dbg_trap_o
);
  import exc_pkg::*;

  logic        int_req;
  logic        ext_req;
  logic        ack;
  exc_pc_sel_e pc_sel;
  exc_cause_u  cause;
  logic        save_cause;

  //////////////////////////////////////////////////////////////////////
  // request and cause generation
  //////////////////////////////////////////////////////////////////////

  exc_controller u_exc_controller (
    .clk            (clk),
    .rst_n          (rst_n),
    .events_i       (events_i),
    .irq_i          (irq_i),
    .irq_id_i       (irq_id_i),
    .irq_enable_i   (mie_o),
    .priv_lvl_i     (priv_lvl_o),
    .dbg_settings_i (dbg_settings_i),
    .ack_i          (ack),
    .int_req_o      (int_req),
    .ext_req_o      (ext_req),
    .pc_sel_o       (pc_sel),
    .cause_o        (cause),
    .save_cause_o   (save_cause),
    .trap_o         (dbg_trap_o)
  );

  // grant under stall and handler fetch
  trap_sequencer u_trap_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .int_req_i (int_req),
    .ext_req_i (ext_req),
    .pc_sel_i  (pc_sel),
    .stall_i   (stall_i),
    .ack_o     (ack),
    .pc_set_o  (pc_set_o),
    .pc_o      (pc_o)
  );

  // machine trap csrs
  exc_csr u_exc_csr (
    .clk          (clk),
    .rst_n        (rst_n),
    .save_cause_i (save_cause),
    .cause_i      (cause),
    .epc_i        (epc_i),
    .mret_i       (mret_i),
    .mcause_o     (mcause_o),
    .mepc_o       (mepc_o),
    .irq_enable_o (mie_o),
    .priv_lvl_o   (priv_lvl_o)
  );

endmodule

// File: hw/exc_csr.sv
`timescale 1ns/1ns
`include "exc_defines.svh"

module exc_csr (
  input  logic                  clk,
  input  logic                  rst_n,
  // trap entry from the exception controller
  input  logic                  save_cause_i,
  input  exc_pkg::exc_cause_u   cause_i,
  // faulting pc
  input  logic [`EXC_XLEN-1:0]  epc_i,
  // return from handler
  input  logic                  mret_i,
  // machine trap state
  output exc_pkg::exc_cause_u   mcause_o,
  output logic [`EXC_XLEN-1:0]  mepc_o,
  output logic                  irq_enable_o,
  output exc_pkg::priv_lvl_e    priv_lvl_o
);
  import exc_pkg::*;

  exc_cause_u           mcause_q;
  logic [`EXC_XLEN-1:0] mepc_q;

  // enable and privilege with a one-deep stack
  logic                 mie_q;
  logic                 mpie_q;
  priv_lvl_e            priv_q;
  priv_lvl_e            mpp_q;

  //////////////////////////////////////////////////////////////////////
  // trap entry and return
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      mcause_q <= '0;
      mepc_q   <= '0;
      mie_q    <= 1'b1;
      mpie_q   <= 1'b1;
      priv_q   <= PRIV_LVL_M;
      mpp_q    <= PRIV_LVL_U;
    end else if (save_cause_i) begin
      // entry wins over a return in the same cycle
      mcause_q <= cause_i;
      mepc_q   <= epc_i;
      mpie_q   <= mie_q;
      mie_q    <= 1'b0;
      mpp_q    <= priv_q;
      priv_q   <= PRIV_LVL_M;
    end else if (mret_i) begin
      // pop the stack
      mie_q  <= mpie_q;
      mpie_q <= 1'b1;
      priv_q <= mpp_q;
      // stack falls back to user after a return
      mpp_q  <= PRIV_LVL_U;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  // all change one cycle after the strobe
  assign mcause_o     = mcause_q;
  assign mepc_o       = mepc_q;
  assign irq_enable_o = mie_q;
  assign priv_lvl_o   = priv_q;

endmodule

// File: hw/trap_sequencer.sv
`timescale 1ns/1ns
`include "exc_defines.svh"

module trap_sequencer (
  input  logic                  clk,
  input  logic                  rst_n,
  // pending requests from the exception controller
  input  logic                  int_req_i,
  input  logic                  ext_req_i,
  input  exc_pkg::exc_pc_sel_e  pc_sel_i,
  // pipeline back-pressure
  input  logic                  stall_i,
  // grant, single-cycle pulse
  output logic                  ack_o,
  // fetch redirect
  output logic                  pc_set_o,
  output logic [`EXC_XLEN-1:0]  pc_o
);

  logic                 pending;
  logic [`EXC_XLEN-1:0] vec_offset;
  logic [`EXC_XLEN-1:0] handler_pc;
  logic                 pc_set_q;
  logic [`EXC_XLEN-1:0] pc_q;

  //////////////////////////////////////////////////////////////////////
  // grant
  //////////////////////////////////////////////////////////////////////

  assign pending = int_req_i | ext_req_i;

  // same cycle as the request unless the pipe is stalled
  assign ack_o = pending & ~stall_i;

  //////////////////////////////////////////////////////////////////////
  // handler address
  //////////////////////////////////////////////////////////////////////

  // four bytes per table slot
  assign vec_offset = {{(`EXC_XLEN-4){1'b0}}, pc_sel_i, 2'b00};
  assign handler_pc = `EXC_VEC_BASE + vec_offset;

  // redirect pulse, one cycle after the grant
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pc_set_q <= 1'b0;
    end else begin
      pc_set_q <= ack_o;
    end
  end

  // target only loads on a grant
  always_ff @(posedge clk) begin
    if (ack_o) begin
      pc_q <= handler_pc;
    end
  end

  assign pc_set_o = pc_set_q;
  assign pc_o     = pc_q;

endmodule

// File: hw/exc_controller.sv
`timescale 1ns/1ns
`include "exc_defines.svh"

module exc_controller (
  input  logic                      clk,
  input  logic                      rst_n,
  // decoder strobes as levels sampled each cycle
  input  exc_pkg::exc_events_t      events_i,
  // level triggered interrupt line
  input  logic                      irq_i,
  input  logic [`EXC_IRQ_ID_W-1:0]  irq_id_i,
  // machine state from the csr block
  input  logic                      irq_enable_i,
  input  exc_pkg::priv_lvl_e        priv_lvl_i,
  // debug trap enables
  input  exc_pkg::dbg_settings_t    dbg_settings_i,
  // handshake with the trap sequencer
  input  logic                      ack_i,
  output logic                      int_req_o,
  output logic                      ext_req_o,
  output exc_pkg::exc_pc_sel_e      pc_sel_o,
  // towards the csr block
  output exc_pkg::exc_cause_u       cause_o,
  output logic                      save_cause_o,
  // towards the debug unit
  output logic                      trap_o
);
  import exc_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_INT,
    WAIT_EXT
  } exc_state_e;

  exc_state_e  state_q;
  exc_state_e  state_d;

  logic        irq_active;
  logic        int_req;
  logic        ext_req;
  logic        new_req;

  exc_cause_u  cause_d;
  exc_cause_u  cause_q;
  exc_pc_sel_e pc_sel_d;
  exc_pc_sel_e pc_sel_q;

  //////////////////////////////////////////////////////////////////////
  // request sources
  //////////////////////////////////////////////////////////////////////

  assign irq_active = irq_i & irq_enable_i;

  // synchronous exceptions go out as internal requests
  // ebreak heads the priority chain and raises no request
  assign int_req = ~events_i.ebrk & (events_i.ecall | events_i.illegal);
  // irq only when no exception is raised in the same cycle
  assign ext_req = irq_active & ~events_i.ebrk & ~events_i.ecall & ~events_i.illegal;
  assign new_req = int_req | ext_req;

  // purely combinational debug trap
  assign trap_o = dbg_settings_i.sste
                | (events_i.ecall   & dbg_settings_i.ecall)
                | (events_i.ebrk    & dbg_settings_i.ebrk)
                | (events_i.illegal & dbg_settings_i.eill)
                | (irq_active       & dbg_settings_i.irq);

  //////////////////////////////////////////////////////////////////////
  // cause and vector select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cause_d.raw = '0;
    pc_sel_d    = EXC_PC_RSVD;

    // lowest priority and overridden by any exception below
    if (irq_active) begin
      cause_d.f.is_irq = 1'b1;
      cause_d.f.code   = irq_id_i;
      pc_sel_d         = EXC_PC_IRQ;
    end

    if (events_i.ebrk) begin
      // cause only and no request
      cause_d.raw = `EXC_CAUSE_BREAKPOINT;
    end else if (events_i.ecall) begin
      if (priv_lvl_i == PRIV_LVL_U) begin
        cause_d.raw = `EXC_CAUSE_ECALL_UMODE;
      end else begin
        cause_d.raw = `EXC_CAUSE_ECALL_MMODE;
      end
      pc_sel_d = EXC_PC_ECALL;
    end else if (events_i.illegal) begin
      cause_d.raw = `EXC_CAUSE_ILLEGAL_INSN;
      pc_sel_d    = EXC_PC_ILLINSN;
    end
  end

  // freeze cause and slot on the first request cycle
  always_ff @(posedge clk) begin
    if (state_q == IDLE && new_req) begin
      cause_q  <= cause_d;
      pc_sel_q <= pc_sel_d;
    end
  end

  // bypass while idle and held copy while waiting
  assign cause_o  = (state_q == IDLE) ? cause_d  : cause_q;
  assign pc_sel_o = (state_q == IDLE) ? pc_sel_d : pc_sel_q;

  //////////////////////////////////////////////////////////////////////
  // request FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    int_req_o    = 1'b0;
    ext_req_o    = 1'b0;
    save_cause_o = 1'b0;

    case (state_q)
      IDLE: begin
        int_req_o = int_req;
        ext_req_o = ext_req;
        if (new_req) begin
          if (ack_i) begin
            // accepted at once so stay idle
            save_cause_o = 1'b1;
          end else if (int_req) begin
            state_d = WAIT_INT;
          end else begin
            state_d = WAIT_EXT;
          end
        end
      end
      WAIT_INT: begin
        int_req_o = 1'b1;
        if (ack_i) begin
          save_cause_o = 1'b1;
          state_d      = IDLE;
        end
      end
      WAIT_EXT: begin
        ext_req_o = 1'b1;
        if (ack_i) begin
          save_cause_o = 1'b1;
          state_d      = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: hw/exc_pkg.sv
`include "exc_defines.svh"

package exc_pkg;

  // privilege levels, encoded as in the mstatus mpp field
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // handler table slot
  typedef enum logic [1:0] {
    EXC_PC_IRQ     = 2'b00,
    EXC_PC_ECALL   = 2'b01,
    EXC_PC_ILLINSN = 2'b10,
    EXC_PC_RSVD    = 2'b11
  } exc_pc_sel_e;

  // cause word split into flag and code
  typedef struct packed {
    logic                     is_irq;
    logic [`EXC_IRQ_ID_W-1:0] code;
  } exc_cause_fields_t;

  // same six bits, either raw or split
  typedef union packed {
    logic [`EXC_CAUSE_W-1:0] raw;
    exc_cause_fields_t       f;
  } exc_cause_u;

  // debug unit trap enables
  typedef struct packed {
    logic sste;   // single step, traps every cycle
    logic ecall;
    logic ebrk;
    logic eill;
    logic irq;
  } dbg_settings_t;

  // decoder strobes
  typedef struct packed {
    logic ebrk;
    logic ecall;
    logic illegal;
  } exc_events_t;

endpackage

// File: hw/exc_defines.svh
`ifndef EXC_DEFINES_SVH
`define EXC_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////

// cause word, interrupt flag on top of the code field
`define EXC_CAUSE_W   6
`define EXC_IRQ_ID_W  5

// fetch address width
`define EXC_XLEN      32

//////////////////////////////////////////////////////////////////////
// handler vector layout
//////////////////////////////////////////////////////////////////////

// one word per slot, slot index is the pc select value
`define EXC_VEC_BASE  32'h0000_0100

//////////////////////////////////////////////////////////////////////
// exception codes, interrupt flag clear
//////////////////////////////////////////////////////////////////////

`define EXC_CAUSE_ILLEGAL_INSN  6'h02
`define EXC_CAUSE_BREAKPOINT    6'h03
`define EXC_CAUSE_ECALL_UMODE   6'h08
`define EXC_CAUSE_ECALL_MMODE   6'h0B

`endif
